// File: hdl/cbr_pkg.sv
`default_nettype none

package cbr_pkg;

  ////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////

  // feature word and weight
  localparam int pix_w = 8;
  // per-cell accumulator
  localparam int acc_w = 32;
  // signed requant scale E
  localparam int scale_w = 16;
  // signed per-channel bias
  localparam int bias_w = 32;
  // scale times sum, room for the bias add
  localparam int prod_w = 48;
  // requantized result word
  localparam int out_w = 8;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // scale selection, latched at reset
  typedef enum logic [3:0] {
    mode_per_tensor  = 4'd0,
    // each row has its own scale
    mode_per_channel = 4'd1
  } cbr_mode_e;

  // kernel controller phase
  typedef enum logic [1:0] {
    phase_idle,
    // counting accepted feature words
    phase_accum,
    // array counter running, rows presented
    phase_drain
  } ctrl_phase_e;

endpackage

`default_nettype wire

// File: hdl/cbr_kernel_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cbr_kernel_controller #(
  parameter int row_num = 16
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        fm_en,
  input  wire        fm_end,
  input  wire  [3:0] mode_init,
  input  wire [31:0] nif_k_k_init,
  input  wire  [7:0] pof_per_core,
  output logic       cell_en,
  output logic       cell_clear,
  output logic [5:0] row_idx,
  output logic       recv_en,
  output logic       mult_en,
  output logic       mult_array_mode,
  output logic       bias_en,
  output logic       relu_en,
  output logic       clamp_en,
  output logic       fifo_wr
);

  // settle counts before row 0 is presented
  localparam logic [8:0] settle = 9'(row_num - 1);

  cbr_pkg::cbr_mode_e   mode;
  cbr_pkg::ctrl_phase_e phase;
  logic [31:0]          nif_k_k;
  logic [31:0]          pix_cnt;
  logic [8:0]           arr_cnt;
  logic [8:0]           arr_last;
  logic                 word_ok;
  logic                 last_word;
  logic                 arr_done;

  ////////////////////////////////////////
  // configuration, held from reset
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mode    <= cbr_pkg::cbr_mode_e'(mode_init);
      nif_k_k <= nif_k_k_init;
    end
  end

  // no words taken while the column drains
  assign word_ok   = fm_en && !fm_end && (phase != cbr_pkg::phase_drain);
  assign last_word = word_ok && (pix_cnt == nif_k_k - 32'd1);
  assign arr_last  = settle + {1'b0, pof_per_core};
  assign arr_done  = (phase == cbr_pkg::phase_drain) && (arr_cnt == arr_last);

  ////////////////////////////////////////
  // phase FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= cbr_pkg::phase_idle;
    end else begin
      case (phase)
        cbr_pkg::phase_idle, cbr_pkg::phase_accum: begin
          // abort strobe drops the partial tile
          if (fm_end) begin
            phase <= cbr_pkg::phase_idle;
          end else if (last_word) begin
            phase <= cbr_pkg::phase_drain;
          end else if (word_ok) begin
            phase <= cbr_pkg::phase_accum;
          end
        end
        cbr_pkg::phase_drain: begin
          if (arr_done) begin
            phase <= cbr_pkg::phase_idle;
          end
        end
        default: phase <= cbr_pkg::phase_idle;
      endcase
    end
  end

  // accepted words of this tile
  always_ff @(posedge clk) begin
    if (reset || fm_end || last_word) begin
      pix_cnt <= '0;
    end else if (word_ok) begin
      pix_cnt <= pix_cnt + 32'd1;
    end
  end

  // array counter starts the cycle after the last word
  always_ff @(posedge clk) begin
    if (reset || arr_done) begin
      arr_cnt <= '0;
    end else if (phase == cbr_pkg::phase_drain) begin
      arr_cnt <= arr_cnt + 9'd1;
    end
  end

  ////////////////////////////////////////
  // cell strobes and stage enables
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cell_en    <= 1'b0;
      cell_clear <= 1'b0;
      row_idx    <= '0;
      recv_en    <= 1'b0;
    end else begin
      // trails the accepted word to line up with the column input regs
      cell_en    <= word_ok;
      // one cycle after the last presented row
      cell_clear <= arr_done;
      if ((phase == cbr_pkg::phase_drain) && (arr_cnt >= settle)
          && (arr_cnt < arr_last)) begin
        row_idx <= 6'(arr_cnt - settle);
        recv_en <= 1'b1;
      end else begin
        row_idx <= '0;
        recv_en <= 1'b0;
      end
    end
  end

  // enable chain advancing one stage per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      mult_en         <= 1'b0;
      mult_array_mode <= 1'b0;
      bias_en         <= 1'b0;
      relu_en         <= 1'b0;
      clamp_en        <= 1'b0;
      fifo_wr         <= 1'b0;
    end else begin
      mult_en         <= recv_en;
      mult_array_mode <= recv_en && (mode == cbr_pkg::mode_per_channel);
      bias_en         <= mult_en;
      relu_en         <= bias_en;
      clamp_en        <= relu_en;
      fifo_wr         <= clamp_en;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // presented rows stay inside the channels in use
  a_row_in_range: assert property (@(posedge clk) disable iff (reset)
    recv_en |-> ({2'b00, row_idx} < pof_per_core))
    else $error("row_idx %0d beyond pof_per_core %0d", row_idx, pof_per_core);

  // a word offered while the column drains would never reach the cells
  a_drain_no_accum: assert property (@(posedge clk) disable iff (reset)
    (phase == cbr_pkg::phase_drain) |-> !(fm_en && !fm_end))
    else $error("feature word offered during drain");

endmodule

`default_nettype wire

// File: hdl/mac_column.sv
`timescale 1ns/1ps
`default_nettype none

module mac_column #(
  parameter int row_num = 16
) (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                cell_en,
  input  wire                                cell_clear,
  input  wire        [cbr_pkg::pix_w-1:0]         fm_data,
  input  wire        [row_num*cbr_pkg::pix_w-1:0] weights,
  input  wire        [5:0]                        row_idx,
  output logic       [cbr_pkg::acc_w-1:0]         sum_out
);

  localparam int row_w = (row_num > 1) ? $clog2(row_num) : 1;

  // broadcast word, registered once
  logic signed [cbr_pkg::pix_w-1:0] fm_q;
  // accumulators gathered for the drain mux
  logic signed [cbr_pkg::acc_w-1:0] acc_bus [row_num];

  always_ff @(posedge clk) begin
    fm_q <= fm_data;
  end

  ////////////////////////////////////////
  // one MAC cell per output channel
  ////////////////////////////////////////

  for (genvar i = 0; i < row_num; i++) begin : g_cell
    logic signed [cbr_pkg::pix_w-1:0]   w_q;
    logic signed [2*cbr_pkg::pix_w-1:0] prod;
    logic signed [cbr_pkg::acc_w-1:0]   acc;

    // weight lines up with fm_q and cell_en
    always_ff @(posedge clk) begin
      w_q <= weights[i*cbr_pkg::pix_w +: cbr_pkg::pix_w];
    end

    // signed 8x8
    assign prod = fm_q * w_q;

    always_ff @(posedge clk) begin
      if (reset || cell_clear) begin
        acc <= '0;
      end else if (cell_en) begin
        // prod sign-extends into the add
        acc <= acc + prod;
      end
    end

    assign acc_bus[i] = acc;
  end

  ////////////////////////////////////////
  // drain mux
  ////////////////////////////////////////

  // registered, this is the receive stage of the requant chain
  always_ff @(posedge clk) begin
    sum_out <= acc_bus[row_idx[row_w-1:0]];
  end

endmodule

`default_nettype wire

// File: hdl/requant_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module requant_pipeline #(
  parameter int row_num = 16
) (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire  [cbr_pkg::acc_w-1:0]              sum_in,
  input  wire  [5:0]                             row_idx,
  input  wire                                    recv_en,
  input  wire                                    mult_en,
  input  wire                                    mult_array_mode,
  input  wire                                    bias_en,
  input  wire                                    relu_en,
  input  wire                                    clamp_en,
  input  wire  [row_num*cbr_pkg::scale_w-1:0]    scales,
  input  wire  [row_num*cbr_pkg::bias_w-1:0]     biases,
  input  wire  [4:0]                             shift,
  output logic [cbr_pkg::out_w-1:0]              result
);

  localparam int row_w = (row_num > 1) ? $clog2(row_num) : 1;
  localparam logic signed [cbr_pkg::prod_w-1:0] clamp_max = 127;

  logic signed [cbr_pkg::scale_w-1:0] scale_arr [row_num];
  logic signed [cbr_pkg::bias_w-1:0]  bias_arr  [row_num];
  logic signed [cbr_pkg::scale_w-1:0] scale_sel;
  // row carried alongside the data
  logic        [row_w-1:0]            row_r;
  logic        [row_w-1:0]            row_m;
  logic signed [cbr_pkg::prod_w-1:0]  prod;
  logic signed [cbr_pkg::prod_w-1:0]  biased;
  logic signed [cbr_pkg::prod_w-1:0]  relu_q;

  for (genvar i = 0; i < row_num; i++) begin : g_unpack
    assign scale_arr[i] = scales[i*cbr_pkg::scale_w +: cbr_pkg::scale_w];
    assign bias_arr[i]  = biases[i*cbr_pkg::bias_w +: cbr_pkg::bias_w];
  end

  // per-tensor falls back to row 0
  assign scale_sel = mult_array_mode ? scale_arr[row_r] : scale_arr[0];

  ////////////////////////////////////////
  // stages
  ////////////////////////////////////////

  // receive, sum itself sits in the column output reg
  always_ff @(posedge clk) begin
    if (recv_en) begin
      row_r <= row_idx[row_w-1:0];
    end
  end

  // scale multiply, 32x16 into 48
  always_ff @(posedge clk) begin
    if (mult_en) begin
      prod  <= $signed(sum_in) * scale_sel;
      row_m <= row_r;
    end
  end

  // bias add
  always_ff @(posedge clk) begin
    if (bias_en) begin
      biased <= prod + bias_arr[row_m];
    end
  end

  // relu then right shift
  always_ff @(posedge clk) begin
    if (relu_en) begin
      if (biased[cbr_pkg::prod_w-1]) begin
        relu_q <= '0;
      end else begin
        relu_q <= biased >>> shift;
      end
    end
  end

  // clamp to 0..127, relu already removed negatives
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (clamp_en) begin
      if (relu_q > clamp_max) begin
        result <= 8'd127;
      end else begin
        result <= relu_q[cbr_pkg::out_w-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/conv_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module conv_out_fifo #(
  parameter int fifo_depth = 32
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         wr_en,
  input  wire  [cbr_pkg::out_w-1:0]   wr_data,
  input  wire                         rd_en,
  output logic [cbr_pkg::out_w-1:0]   rd_data,
  output logic                        empty
);

  // depth is a power of two, pointers wrap on their own
  localparam int ptr_w = $clog2(fifo_depth);

  logic [cbr_pkg::out_w-1:0] mem [fifo_depth];
  logic [ptr_w-1:0]          wr_ptr;
  logic [ptr_w-1:0]          rd_ptr;
  logic [ptr_w:0]            count;
  logic                      full;
  logic                      do_wr;
  logic                      do_rd;

  assign full  = (count == (ptr_w+1)'(fifo_depth));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
    // registered read, valid the cycle after rd_en
    if (do_rd) begin
      rd_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (ptr_w+1)'(do_wr) - (ptr_w+1)'(do_rd);
    end
  end

  // compute path has no stall, a full fifo loses results
  a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr_en |-> !full)
    else $error("write into full fifo");

  a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
    else $error("read from empty fifo");

endmodule

`default_nettype wire

// File: hdl/cbr_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module cbr_core_top #(
  parameter int row_num    = 16,
  parameter int fifo_depth = 32
) (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire  [3:0]                           mode_init,
  input  wire  [31:0]                          nif_k_k_init,
  input  wire                                  fm_en,
  input  wire                                  fm_end,
  input  wire  [cbr_pkg::pix_w-1:0]            fm_data,
  input  wire  [row_num*cbr_pkg::pix_w-1:0]    weights,
  input  wire  [7:0]                           pof_per_core,
  input  wire  [row_num*cbr_pkg::scale_w-1:0]  scales,
  input  wire  [row_num*cbr_pkg::bias_w-1:0]   biases,
  input  wire  [4:0]                           shift,
  input  wire                                  rd_en,
  output wire  [cbr_pkg::out_w-1:0]            rd_data,
  output wire                                  empty
);

  ////////////////////////////////////////
  // controller to datapath
  ////////////////////////////////////////

  wire                       cell_en;
  wire                       cell_clear;
  wire [5:0]                 row_idx;
  wire                       recv_en;
  wire                       mult_en;
  wire                       mult_array_mode;
  wire                       bias_en;
  wire                       relu_en;
  wire                       clamp_en;
  wire                       fifo_wr;
  // drained sum, then the requantized word
  wire [cbr_pkg::acc_w-1:0]  sum_out;
  wire [cbr_pkg::out_w-1:0]  wr_data;

  cbr_kernel_controller #(.row_num(row_num)) ctrl0 (
    .clk(clk), .reset(reset), .fm_en(fm_en), .fm_end(fm_end),
    .mode_init(mode_init), .nif_k_k_init(nif_k_k_init), .pof_per_core(pof_per_core),
    .cell_en(cell_en), .cell_clear(cell_clear), .row_idx(row_idx),
    .recv_en(recv_en), .mult_en(mult_en), .mult_array_mode(mult_array_mode),
    .bias_en(bias_en), .relu_en(relu_en), .clamp_en(clamp_en), .fifo_wr(fifo_wr)
  );

  mac_column #(.row_num(row_num)) col0 (
    .clk(clk), .reset(reset), .cell_en(cell_en), .cell_clear(cell_clear),
    .fm_data(fm_data), .weights(weights), .row_idx(row_idx), .sum_out(sum_out)
  );

  requant_pipeline #(.row_num(row_num)) rq0 (
    .clk(clk), .reset(reset), .sum_in(sum_out), .row_idx(row_idx),
    .recv_en(recv_en), .mult_en(mult_en), .mult_array_mode(mult_array_mode),
    .bias_en(bias_en), .relu_en(relu_en), .clamp_en(clamp_en),
    .scales(scales), .biases(biases), .shift(shift), .result(wr_data)
  );

  // last enable of the chain is the write strobe
  conv_out_fifo #(.fifo_depth(fifo_depth)) fifo0 (
    .clk(clk), .reset(reset), .wr_en(fifo_wr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_data(rd_data), .empty(empty)
  );

endmodule

`default_nettype wire

// File: verification/tb_cbr_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cbr_core;

  localparam int row_num      = 16;
  localparam int fifo_depth   = 32;
  localparam int reset_cycles = 16;
  localparam int max_words    = 64;
  // tile lengths for the two reset configurations
  localparam int nif_a        = 24;
  localparam int nif_b        = 37;
  localparam int gap_max      = 3;
  localparam int small_pof    = (row_num > 4) ? 5 : 3;
  // tests 1..5 one tile each, test 6 two tiles
  localparam int n_tiles      = 7;
  localparam int tile_cycles  = nif_b * (gap_max + 1) + row_num * 3 + 40;
  localparam int watchdog_cycles = n_tiles * tile_cycles + 3 * (reset_cycles + 4);

  logic                         clk;
  logic                         reset;
  logic [3:0]                   mode_init;
  logic [31:0]                  nif_k_k_init;
  logic                         fm_en;
  logic                         fm_end;
  logic [7:0]                   fm_data;
  logic [row_num*8-1:0]         weights;
  logic [7:0]                   pof_per_core;
  logic [row_num*16-1:0]        scales;
  logic [row_num*32-1:0]        biases;
  logic [4:0]                   shift;
  logic                         rd_en = 1'b0;
  wire  [7:0]                   rd_data;
  wire                          empty;

  integer                       seed;
  int                           errors;
  int                           checks;
  int                           n_read;
  int                           cur_nif;
  int                           cur_pof;
  logic [3:0]                   cur_mode;
  logic [7:0]                   tile_words [max_words];
  logic [7:0]                   tile_wts   [max_words][row_num];
  logic signed [15:0]           scale_v    [row_num];
  logic signed [31:0]           bias_v     [row_num];
  // expected results and their rows, in fifo order
  logic [7:0]                   exp_q [$];
  int                           row_q [$];
  logic                         rd_pend = 1'b0;
  logic [7:0]                   exp_v;
  int                           exp_row;
  int                           base;

  cbr_core_top #(.row_num(row_num), .fifo_depth(fifo_depth)) dut0 (
    .clk(clk), .reset(reset), .mode_init(mode_init), .nif_k_k_init(nif_k_k_init),
    .fm_en(fm_en), .fm_end(fm_end), .fm_data(fm_data), .weights(weights),
    .pof_per_core(pof_per_core), .scales(scales), .biases(biases), .shift(shift),
    .rd_en(rd_en), .rd_data(rd_data), .empty(empty)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // dot product, scale, bias, relu, shift, clamp
  function automatic logic [7:0] ref_cbr(
    input logic [7:0]         words [max_words],
    input logic [7:0]         wts [max_words],
    input int                 n,
    input logic signed [15:0] scale,
    input logic signed [31:0] bias,
    input logic [4:0]         sh
  );
    longint dot;
    longint val;
    dot = 0;
    for (int i = 0; i < n; i++) begin
      dot = dot + longint'($signed(words[i])) * longint'($signed(wts[i]));
    end
    val = dot * longint'(scale) + longint'(bias);
    if (val < 0) begin
      val = 0;
    end else begin
      val = val >>> sh;
    end
    if (val > 127) begin
      return 8'd127;
    end
    return val[7:0];
  endfunction

  ////////////////////////////////////////
  // fifo reader and compare
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (reset) begin
      rd_en   = 1'b0;
      rd_pend = 1'b0;
    end else begin
      // data of last cycle's read is now on rd_data
      if (rd_pend) begin
        n_read++;
        if (exp_q.size() == 0) begin
          $display("unexpected result %0d read at %0t with nothing expected", rd_data, $time);
          errors++;
        end else begin
          exp_v   = exp_q.pop_front();
          exp_row = row_q.pop_front();
          checks++;
          if (rd_data !== exp_v) begin
            $display("FAIL %0t: row %0d result %0d, expected %0d",
                     $time, exp_row, rd_data, exp_v);
            errors++;
          end
        end
      end
      rd_en   = !empty;
      rd_pend = !empty;
    end
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  // mode and tile length only latch while reset is high
  task automatic apply_reset(input logic [3:0] mode, input int nif);
    @(negedge clk);
    reset        = 1'b1;
    mode_init    = mode;
    nif_k_k_init = 32'(nif);
    repeat (reset_cycles) @(negedge clk);
    reset    = 1'b0;
    cur_mode = mode;
    cur_nif  = nif;
    if (empty !== 1'b1) begin
      $display("fifo not empty after reset at %0t", $time);
      errors++;
    end
  endtask

  task automatic drive_setup(input int pof, input int sh);
    @(negedge clk);
    cur_pof      = pof;
    pof_per_core = 8'(pof);
    shift        = 5'(sh);
    for (int r = 0; r < row_num; r++) begin
      scales[r*16 +: 16] = scale_v[r];
      biases[r*32 +: 32] = bias_v[r];
    end
  endtask

  // random signed scales and moderate biases
  task automatic pick_setup(input int pof, input int sh);
    for (int r = 0; r < row_num; r++) begin
      scale_v[r] = 16'($random(seed) % 64);
      bias_v[r]  = 32'($random(seed) % 65536);
    end
    drive_setup(pof, sh);
  endtask

  // even rows far positive, odd rows far negative
  task automatic saturating_setup(input int sh);
    for (int r = 0; r < row_num; r++) begin
      scale_v[r] = 16'(1 + $unsigned($random(seed)) % 4);
      bias_v[r]  = (r % 2 == 0) ? 32'sh4000_0000 : -32'sh4000_0000;
    end
    drive_setup(row_num, sh);
  endtask

  task automatic make_tile();
    for (int i = 0; i < cur_nif; i++) begin
      tile_words[i] = 8'($random(seed));
      for (int r = 0; r < row_num; r++) begin
        tile_wts[i][r] = 8'($random(seed));
      end
    end
  endtask

  task automatic queue_expected();
    logic [7:0]         row_wts [max_words];
    logic signed [15:0] s;
    for (int r = 0; r < cur_pof; r++) begin
      for (int i = 0; i < max_words; i++) begin
        row_wts[i] = (i < cur_nif) ? tile_wts[i][r] : 8'd0;
      end
      // per-tensor takes row 0's scale for every row
      s = (cur_mode == 4'(cbr_pkg::mode_per_channel)) ? scale_v[r] : scale_v[0];
      exp_q.push_back(ref_cbr(tile_words, row_wts, cur_nif, s, bias_v[r], shift));
      row_q.push_back(r);
    end
  endtask

  task automatic send_tile(input bit gaps);
    int gap;
    for (int i = 0; i < cur_nif; i++) begin
      if (gaps) begin
        gap = $unsigned($random(seed)) % (gap_max + 1);
        repeat (gap) begin
          @(negedge clk);
          fm_en = 1'b0;
        end
      end
      @(negedge clk);
      fm_en   = 1'b1;
      fm_data = tile_words[i];
      for (int r = 0; r < row_num; r++) begin
        weights[r*8 +: 8] = tile_wts[i][r];
      end
    end
    @(negedge clk);
    fm_en = 1'b0;
  endtask

  // all queued results read, then nothing more may show up
  task automatic wait_drained(input int n_exp, input int read_base);
    while (exp_q.size() != 0 || rd_pend) @(negedge clk);
    repeat (10) @(negedge clk);
    if (empty !== 1'b1) begin
      $display("fifo still holds results after the tile at %0t", $time);
      errors++;
    end
    if (n_read - read_base != n_exp) begin
      $display("read %0d results where %0d were expected", n_read - read_base, n_exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_base);
    if (errors == err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_base);
    end
  endtask

  task automatic run_tile(input bit gaps);
    int rb;
    rb = n_read;
    make_tile();
    queue_expected();
    send_tile(gaps);
    wait_drained(cur_pof, rb);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    seed         = 95;
    errors       = 0;
    checks       = 0;
    n_read       = 0;
    reset        = 1'b1;
    mode_init    = 4'd0;
    nif_k_k_init = 32'(nif_a);
    fm_en        = 1'b0;
    fm_end       = 1'b0;
    fm_data      = '0;
    weights      = '0;
    pof_per_core = 8'(row_num);
    scales       = '0;
    biases       = '0;
    shift        = '0;

    apply_reset(4'(cbr_pkg::mode_per_channel), nif_a);
    base = errors;
    pick_setup(row_num, 13);
    run_tile(1'b0);
    report_test("1 per-channel full tile", base);

    apply_reset(4'(cbr_pkg::mode_per_tensor), nif_a);
    base = errors;
    pick_setup(row_num, 13);
    run_tile(1'b0);
    report_test("2 per-tensor scale", base);

    // remaining tests share one per-channel configuration
    apply_reset(4'(cbr_pkg::mode_per_channel), nif_b);
    base = errors;
    pick_setup(small_pof, 13);
    run_tile(1'b0);
    report_test("3 partial output channels", base);

    base = errors;
    pick_setup(row_num, 13);
    run_tile(1'b1);
    report_test("4 gaps in fm_en", base);

    base = errors;
    saturating_setup(4);
    run_tile(1'b0);
    report_test("5 saturation and relu", base);

    // second tile right after the first drains
    base = errors;
    pick_setup(row_num, 13);
    run_tile(1'b0);
    run_tile(1'b0);
    report_test("6 back-to-back tiles", base);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // hard stop if a tile never drains
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hdl/cbr_pkg.sv
hdl/cbr_kernel_controller.sv
hdl/mac_column.sv
hdl/requant_pipeline.sv
hdl/conv_out_fifo.sv
hdl/cbr_core_top.sv
verification/tb_cbr_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cbr_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'TEST PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
